// File: design/lenet_mac_pkg.sv
package lenet_mac_pkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // Unsigned input pixel
    localparam int PIXEL_W = 8;

    // Unsigned kernel weight
    localparam int WEIGHT_W = 8;

    // Output of the approximate multiplier, truncated to this width
    localparam int PROD_W = 16;

    // Bias is two's complement and is sign-extended before the add
    localparam int BIAS_W = 16;

    //////////////////////////////
    // Output stage
    //////////////////////////////

    // Activation after ReLU, shift and clamp
    localparam int ACT_W = 8;

endpackage

// File: design/approx_mul_8x8.sv
`timescale 1ns/1ns

module approx_mul_8x8 (
    input  logic [7:0]  x,
    input  logic [7:0]  y,
    output logic [15:0] z
);

    // pp[i] is y gated by x[i], weight 2^i
    logic [7:0][7:0]  pp;

    // Compressed replacement for rows 0 to 5
    logic [5:0][12:0] cv;

    logic [15:0] row6_ext;
    logic [15:0] row7_ext;
    logic [15:0] cv_sum;

    //////////////////////////////
    // Partial products
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    //////////////////////////////
    // Approximate lower rows
    //////////////////////////////

    // Each term combines one bit of a row with a bit of the next row
    // and is placed at a fixed position. Bits not listed stay zero
    always_comb begin
        cv = '0;

        // First vector covers the widest spread of positions
        cv[0][2]  = pp[0][1] & pp[1][0];
        cv[0][5]  = pp[0][5] & pp[1][4];
        cv[0][6]  = pp[0][5] ^ pp[1][4];
        cv[0][7]  = pp[0][7] | pp[1][6];
        cv[0][8]  = pp[0][7] & pp[1][6];
        cv[0][9]  = pp[2][6] | pp[3][5];
        cv[0][10] = pp[3][7];
        cv[0][11] = pp[4][7] & pp[5][6];
        cv[0][12] = pp[5][7];

        cv[1][5]  = pp[4][1] & pp[5][0];
        cv[1][6]  = pp[2][4] & pp[3][3];
        cv[1][7]  = pp[4][3] | pp[5][2];
        cv[1][8]  = pp[1][7];
        cv[1][9]  = pp[2][7] ^ pp[3][6];
        cv[1][10] = pp[4][5] & pp[5][4];
        cv[1][11] = pp[4][7] | pp[5][6];

        cv[2][6]  = pp[2][4] ^ pp[3][3];
        cv[2][8]  = pp[2][6] & pp[3][5];
        cv[2][9]  = pp[4][4] & pp[5][3];
        cv[2][10] = pp[4][6] | pp[5][5];

        cv[3][6]  = pp[4][1] & pp[5][0];
        cv[3][9]  = pp[4][4] ^ pp[5][3];

        // Last two vectors only feed bit 9
        cv[4][9]  = pp[4][5] & pp[5][4];
        cv[5][9]  = pp[4][5] | pp[5][4];
    end

    //////////////////////////////
    // Final sum
    //////////////////////////////

    // Rows 6 and 7 are kept exact, they carry most of the magnitude
    assign row6_ext = {2'b00, pp[6], 6'b000000};
    assign row7_ext = {1'b0, pp[7], 7'b0000000};

    always_comb begin
        cv_sum = '0;
        for (int k = 0; k < 6; k++) begin
            cv_sum = cv_sum + {3'b000, cv[k]};
        end
    end

    // Carries beyond bit 15 are dropped
    assign z = row6_ext + row7_ext + cv_sum;

endmodule

// File: design/weight_bank.sv
`timescale 1ns/1ns

module weight_bank #(
    parameter  int TAPS  = 25,
    localparam int IDX_W = $clog2(TAPS + 1)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          weight_we,
    input  logic [IDX_W-1:0]              weight_addr,
    input  logic [lenet_mac_pkg::WEIGHT_W-1:0] weight_data,
    input  logic [lenet_mac_pkg::BIAS_W-1:0]   bias_data,
    input  logic [IDX_W-1:0]              tap,
    output logic [lenet_mac_pkg::WEIGHT_W-1:0] weight,
    output logic [lenet_mac_pkg::BIAS_W-1:0]   bias
);

    import lenet_mac_pkg::*;

    logic [WEIGHT_W-1:0] w_q [TAPS];
    logic [BIAS_W-1:0]   bias_q;
    logic [BIAS_W-1:0]   bias_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TAPS; i++) begin
                w_q[i] <= '0;
            end
            bias_q    <= '0;
            bias_hold <= '0;
        end else begin
            if (weight_we) begin
                if (weight_addr == IDX_W'(TAPS)) begin
                    bias_q <= bias_data;
                end else begin
                    w_q[weight_addr] <= weight_data;
                end
            end
            // Bias follows the bank only while a window is in flight, so a
            // rewrite after the last pixel cannot reach the draining result
            if (tap != '0) begin
                bias_hold <= bias_q;
            end
        end
    end

    assign weight = w_q[tap];
    assign bias   = bias_hold;

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        weight_we |-> weight_addr <= IDX_W'(TAPS))
        else $error("weight_addr out of range");

endmodule

// File: design/window_mac.sv
`timescale 1ns/1ns

module window_mac #(
    parameter  int TAPS  = 25,
    parameter  int ACC_W = 22,
    localparam int IDX_W = $clog2(TAPS + 1)
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               pixel_valid,
    input  logic [lenet_mac_pkg::PIXEL_W-1:0]  pixel,
    input  logic [lenet_mac_pkg::WEIGHT_W-1:0] weight,
    output logic [IDX_W-1:0]                   tap,
    output logic                               busy,
    output logic [ACC_W-1:0]                   sum,
    output logic                               sum_valid
);

    import lenet_mac_pkg::*;

    logic [PROD_W-1:0] prod;
    logic [PROD_W-1:0] prod_q;
    logic              prod_valid;
    logic              prod_first;
    logic              prod_last;

    logic [ACC_W-1:0]  acc;
    logic              acc_done;

    logic              tap_last;

    //////////////////////////////
    // Tap counter
    //////////////////////////////

    assign tap_last = (tap == IDX_W'(TAPS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap <= '0;
        end else if (pixel_valid) begin
            tap <= tap_last ? '0 : tap + 1'b1;
        end
    end

    assign busy = (tap != '0);

    //////////////////////////////
    // Product stage
    //////////////////////////////

    approx_mul_8x8 i_approx_mul_8x8 (
        .x (pixel),
        .y (weight),
        .z (prod)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= pixel_valid;
            prod_first <= pixel_valid && (tap == '0);
            prod_last  <= pixel_valid && tap_last;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            prod_q <= prod;
        end
    end

    //////////////////////////////
    // Accumulator
    //////////////////////////////

    // The first product overwrites, so no separate clear cycle is needed
    // between windows
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc      <= '0;
            acc_done <= 1'b0;
        end else begin
            acc_done <= prod_valid && prod_last;
            if (prod_valid) begin
                acc <= prod_first ? ACC_W'(prod_q) : acc + ACC_W'(prod_q);
            end
        end
    end

    // Hand-off register frees acc for the next window on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= acc_done;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_done) begin
            sum <= acc;
        end
    end

    a_sum_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sum_valid |=> !sum_valid)
        else $error("sum_valid held for two cycles");

endmodule

// File: design/relu_requant.sv
`timescale 1ns/1ns

module relu_requant #(
    parameter int ACC_W     = 22,
    parameter int OUT_SHIFT = 6
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sum_valid,
    input  logic [ACC_W-1:0]                 sum,
    input  logic [lenet_mac_pkg::BIAS_W-1:0] bias,
    output logic                             result_valid,
    output logic [lenet_mac_pkg::ACT_W-1:0]  result
);

    import lenet_mac_pkg::*;

    // Two spare bits keep the signed add from overflowing
    localparam int TOT_W = ((ACC_W > BIAS_W) ? ACC_W : BIAS_W) + 2;

    logic signed [TOT_W-1:0] total;
    logic        [TOT_W-1:0] shifted;
    logic        [ACT_W-1:0] act;

    assign total   = TOT_W'(signed'({1'b0, sum})) + TOT_W'(signed'(bias));
    assign shifted = total >>> OUT_SHIFT;

    always_comb begin
        if (total < 0) begin
            act = '0;
        end else if (shifted > TOT_W'({ACT_W{1'b1}})) begin
            act = {ACT_W{1'b1}};
        end else begin
            act = shifted[ACT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            result <= act;
        end
    end

endmodule

// File: design/lenet_conv_unit.sv
`timescale 1ns/1ns

module lenet_conv_unit #(
    parameter  int TAPS      = 25,
    parameter  int ACC_W     = 22,
    parameter  int OUT_SHIFT = 6,
    localparam int IDX_W     = $clog2(TAPS + 1)
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               weight_we,
    input  logic [IDX_W-1:0]                   weight_addr,
    input  logic [lenet_mac_pkg::WEIGHT_W-1:0] weight_data,
    input  logic [lenet_mac_pkg::BIAS_W-1:0]   bias_data,
    input  logic                               pixel_valid,
    input  logic [lenet_mac_pkg::PIXEL_W-1:0]  pixel,
    output logic                               result_valid,
    output logic [lenet_mac_pkg::ACT_W-1:0]    result
);

    import lenet_mac_pkg::*;

    logic [IDX_W-1:0]    tap;
    logic                busy;
    logic [WEIGHT_W-1:0] weight;
    logic [BIAS_W-1:0]   bias;
    logic [ACC_W-1:0]    sum;
    logic                sum_valid;

    weight_bank #(.TAPS(TAPS)) i_weight_bank (
        .clk(clk), .rst_n(rst_n),
        .weight_we(weight_we), .weight_addr(weight_addr),
        .weight_data(weight_data), .bias_data(bias_data),
        .tap(tap), .weight(weight), .bias(bias)
    );

    window_mac #(.TAPS(TAPS), .ACC_W(ACC_W)) i_window_mac (
        .clk(clk), .rst_n(rst_n),
        .pixel_valid(pixel_valid), .pixel(pixel), .weight(weight),
        .tap(tap), .busy(busy), .sum(sum), .sum_valid(sum_valid)
    );

    relu_requant #(.ACC_W(ACC_W), .OUT_SHIFT(OUT_SHIFT)) i_relu_requant (
        .clk(clk), .rst_n(rst_n),
        .sum_valid(sum_valid), .sum(sum), .bias(bias),
        .result_valid(result_valid), .result(result)
    );

    // Kernel and bias may only change between windows
    a_write_idle: assert property (@(posedge clk) disable iff (!rst_n)
        weight_we |-> !busy)
        else $error("weight write during a window");

endmodule

// File: bench/tb_lenet_conv_unit.sv
`timescale 1ns/1ns

module tb_lenet_conv_unit;

    import lenet_mac_pkg::*;

    localparam int TAPS      = 25;
    localparam int OUT_SHIFT = 6;
    localparam int IDX_W     = $clog2(TAPS + 1);
    localparam int MAX_GAP   = 3;
    localparam int N_SINGLE  = 24;
    localparam int N_RANDOM  = 12;
    localparam int N_BURST   = 8;
    localparam int N_WINDOWS = N_SINGLE + N_RANDOM + 2 + N_BURST + 6;
    // Three-bit weights keep a full window of random pixels mostly below saturation
    localparam int WINDOW_WEIGHT_BITS = 3;
    // Each window may also need a full kernel load in front of it
    localparam int TIMEOUT_CYCLES =
        N_WINDOWS * ((TAPS + MAX_GAP + 4) + TAPS * MAX_GAP + TAPS + 2) + 500;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                weight_we;
    logic [IDX_W-1:0]    weight_addr;
    logic [WEIGHT_W-1:0] weight_data;
    logic [BIAS_W-1:0]   bias_data;
    logic                pixel_valid;
    logic [PIXEL_W-1:0]  pixel;
    logic                result_valid;
    logic [ACT_W-1:0]    result;

    // Reference state for the kernel currently loaded into the DUT
    logic [7:0]  kernel [TAPS];
    logic [15:0] bias_m;
    logic [31:0] lfsr;

    logic [7:0]  exp_q [$];
    int          due_q [$];
    int          cycle_cnt = 0;
    int          errors = 0;
    int          checks = 0;
    int          pulses = 0;
    int          windows = 0;

    lenet_conv_unit i_lenet_conv_unit (
        .clk(clk), .rst_n(rst_n),
        .weight_we(weight_we), .weight_addr(weight_addr),
        .weight_data(weight_data), .bias_data(bias_data),
        .pixel_valid(pixel_valid), .pixel(pixel),
        .result_valid(result_valid), .result(result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////
    // Helpers and reference model
    //////////////////////////////

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %0h, expected %0h at cycle %0d",
                     name, got, expected, cycle_cnt);
        end
    endtask

    // Galois LFSR stepped once for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 32'h80200003;
            end
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    // Bias between -4096 and 4095 moves a window result by up to 64 steps
    function automatic logic [15:0] small_bias();
        return 16'(rand_bits(13)) - 16'd4096;
    endfunction

    function automatic int at(input logic b, input int pos);
        return b ? (1 << pos) : 0;
    endfunction

    // Terms are grouped by output bit position
    function automatic logic [15:0] approx_mul(input logic [7:0] x, input logic [7:0] y);
        logic [7:0] g [6];
        int         s;
        for (int r = 0; r < 6; r++) begin
            g[r] = x[r] ? y : 8'h00;
        end
        s = 0;
        if (x[6]) s += int'(y) << 6;
        if (x[7]) s += int'(y) << 7;
        s += at(g[0][1] & g[1][0], 2);
        s += at(g[0][5] & g[1][4], 5);
        s += at(g[4][1] & g[5][0], 5);
        s += at(g[0][5] ^ g[1][4], 6);
        s += at(g[2][4] & g[3][3], 6);
        s += at(g[2][4] ^ g[3][3], 6);
        s += at(g[4][1] & g[5][0], 6);
        s += at(g[0][7] | g[1][6], 7);
        s += at(g[4][3] | g[5][2], 7);
        s += at(g[0][7] & g[1][6], 8);
        s += at(g[1][7], 8);
        s += at(g[2][6] & g[3][5], 8);
        s += at(g[2][6] | g[3][5], 9);
        s += at(g[2][7] ^ g[3][6], 9);
        s += at(g[4][4] & g[5][3], 9);
        s += at(g[4][4] ^ g[5][3], 9);
        s += at(g[4][5] & g[5][4], 9);
        s += at(g[4][5] | g[5][4], 9);
        s += at(g[3][7], 10);
        s += at(g[4][5] & g[5][4], 10);
        s += at(g[4][6] | g[5][5], 10);
        s += at(g[4][7] & g[5][6], 11);
        s += at(g[4][7] | g[5][6], 11);
        s += at(g[5][7], 12);
        return 16'(s);
    endfunction

    function automatic logic [7:0] requant(input int acc, input logic [15:0] b);
        int total;
        total = acc + int'($signed(b));
        if (total < 0) begin
            return 8'h00;
        end
        total = total >>> OUT_SHIFT;
        if (total > 255) begin
            return 8'hff;
        end
        return total[7:0];
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic load_kernel();
        for (int a = 0; a <= TAPS; a++) begin
            @(negedge clk);
            pixel_valid = 1'b0;
            weight_we   = 1'b1;
            weight_addr = IDX_W'(a);
            weight_data = (a < TAPS) ? kernel[a] : 8'h00;
            bias_data   = bias_m;
        end
        @(negedge clk);
        weight_we = 1'b0;
    endtask

    // A negative fixed_pixel means random pixels
    task automatic run_window(input int max_gap, input int fixed_pixel,
                              output logic [7:0] expect_val);
        int         acc;
        int         gap;
        logic [7:0] px;
        acc = 0;
        for (int t = 0; t < TAPS; t++) begin
            gap = (max_gap > 0) ? int'(rand_bits(8)) % (max_gap + 1) : 0;
            repeat (gap) begin
                @(negedge clk);
                pixel_valid = 1'b0;
            end
            px = (fixed_pixel < 0) ? 8'(rand_bits(8)) : fixed_pixel[7:0];
            @(negedge clk);
            weight_we   = 1'b0;
            pixel_valid = 1'b1;
            pixel       = px;
            acc += int'(approx_mul(px, kernel[t]));
        end
        expect_val = requant(acc, bias_m);
        exp_q.push_back(expect_val);
        // Accepted on the next edge and visible here three edges after that
        due_q.push_back(cycle_cnt + 4);
        windows++;
    endtask

    task automatic drain();
        @(negedge clk);
        pixel_valid = 1'b0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic random_kernel(input int bits);
        for (int i = 0; i < TAPS; i++) begin
            kernel[i] = 8'(rand_bits(bits));
        end
    endtask

    //////////////////////////////
    // Output monitor
    //////////////////////////////

    // result_valid must be low except on the exact cycle a window is due
    always @(negedge clk) begin
        if (rst_n) begin
            if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
                compare("result_valid", {31'b0, result_valid}, 32'd1);
                compare("result", {24'b0, result}, {24'b0, exp_q[0]});
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                compare("result_valid", {31'b0, result_valid}, 32'd0);
            end
            if (result_valid) begin
                pulses++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timed out after %0d cycles before all windows finished", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        int         sel;
        logic [7:0] ev;
        lfsr        = 32'h33ad79e0;
        rst_n       = 1'b0;
        weight_we   = 1'b0;
        weight_addr = '0;
        weight_data = '0;
        bias_data   = '0;
        pixel_valid = 1'b0;
        pixel       = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (5) @(negedge clk);

        // One nonzero tap per window and the first case is the all-ones corner
        for (int c = 0; c < N_SINGLE; c++) begin
            random_kernel(0);
            bias_m      = 16'h0000;
            sel         = int'(rand_bits(8)) % TAPS;
            kernel[sel] = (c == 0) ? 8'hff : 8'(rand_bits(8));
            load_kernel();
            run_window(0, (c == 0) ? 255 : -1, ev);
        end

        for (int c = 0; c < N_RANDOM; c++) begin
            random_kernel(WINDOW_WEIGHT_BITS);
            bias_m = small_bias();
            load_kernel();
            run_window(MAX_GAP, -1, ev);
        end

        // ReLU floor and saturation ceiling
        random_kernel(2);
        bias_m = 16'h8000;
        load_kernel();
        run_window(0, -1, ev);
        compare("relu_expect", {24'b0, ev}, 32'd0);
        for (int i = 0; i < TAPS; i++) begin
            kernel[i] = 8'hff;
        end
        bias_m = 16'h0000;
        load_kernel();
        run_window(0, 255, ev);
        compare("saturate_expect", {24'b0, ev}, 32'd255);

        random_kernel(WINDOW_WEIGHT_BITS);
        bias_m = small_bias();
        load_kernel();
        for (int c = 0; c < N_BURST; c++) begin
            run_window(0, -1, ev);
        end

        // Rewrite lands while the previous window is still draining
        random_kernel(WINDOW_WEIGHT_BITS);
        bias_m = small_bias();
        load_kernel();
        repeat (3) run_window(MAX_GAP, -1, ev);
        random_kernel(WINDOW_WEIGHT_BITS);
        bias_m = small_bias();
        load_kernel();
        repeat (3) run_window(MAX_GAP, -1, ev);

        drain();
        compare("result_count", pulses, windows);
        $display("Windows: %0d, pulses: %0d, checks: %0d, errors: %0d",
                 windows, pulses, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: lenet_conv_unit.f
design/lenet_mac_pkg.sv
design/approx_mul_8x8.sv
design/weight_bank.sv
design/window_mac.sv
design/relu_requant.sv
design/lenet_conv_unit.sv
bench/tb_lenet_conv_unit.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_lenet_conv_unit
FILELIST = lenet_conv_unit.f

OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulator's exit code is not trusted, the log decides
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
